// ==== verilog/cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

    // bank layout
    localparam int NUM_BANKS = 4;
    localparam int BANK_BITS = 2;
    localparam int ROW_WORDS = 2;
    localparam int ROWS      = 128;
    localparam int ROW_BITS  = 7;

    localparam int WORD_BITS = 32;
    localparam int BYTE_BITS = 8;

    typedef logic [WORD_BITS-1:0]              word_t;
    typedef logic [ROW_WORDS*WORD_BITS-1:0]    row_data_t;
    typedef logic [ROW_WORDS*WORD_BITS/8-1:0]  row_mask_t;
    typedef logic [WORD_BITS/8-1:0]            word_mask_t;

    // {row, bank, lane}
    typedef logic [ROW_BITS+BANK_BITS:0]       word_addr_t;
    typedef logic [BANK_BITS-1:0]              bank_t;
    typedef logic [ROW_BITS-1:0]               row_addr_t;

    // one line is the same row across all banks
    typedef logic [ROW_BITS-1:0]               line_addr_t;

endpackage

`default_nettype wire

// ==== verilog/cache_ctrl_pkg.sv ====
`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic [1:0] {
        idle,
        refill,
        evict_issue,
        evict_drain
    } fill_state_t;

    // one row per bank per line
    localparam int LINE_BEATS = 4;

    // bank read, request edge to output register
    localparam int READ_LATENCY = 2;

endpackage

`default_nettype wire

// ==== verilog/cache_port_if.sv ====
`default_nettype none

interface cache_port_if import cache_geom_pkg::*; ();

    logic      en;
    logic      we;
    bank_t     bank_sel;
    row_addr_t row;
    row_data_t data;
    row_mask_t wm;

    modport src (
        output en, we, bank_sel, row, data, wm
    );

    // router side, also watched by the read aligner
    modport bank (
        input en, we, bank_sel, row, data, wm
    );

endinterface

`default_nettype wire

// ==== verilog/store_merge.sv ====
`default_nettype none

module store_merge import cache_geom_pkg::*; (
    input  logic       st_en,
    input  word_addr_t st_addr,
    input  word_t      st_data,
    input  word_mask_t st_mask,
    cache_port_if.src  port
);

    logic      lane;
    bank_t     bank;
    row_addr_t row;

    // address split
    assign lane = st_addr[0];
    assign bank = st_addr[BANK_BITS:1];
    assign row  = st_addr[ROW_BITS+BANK_BITS:BANK_BITS+1];

    assign port.en       = st_en;
    assign port.we       = 1'b1;
    assign port.bank_sel = bank;
    assign port.row      = row;

    // word goes to both lanes, mask picks the one that lands
    assign port.data = {ROW_WORDS{st_data}};

    always_comb begin
        port.wm = '0;
        port.wm[lane*$bits(word_mask_t) +: $bits(word_mask_t)] = st_mask;
    end

endmodule

`default_nettype wire

// ==== verilog/fill_engine.sv ====
`default_nettype none

module fill_engine import cache_geom_pkg::*, cache_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fill_start,
    input  line_addr_t fill_addr,
    input  logic       fill_valid,
    input  row_data_t  fill_data,
    input  logic       evict_start,
    input  line_addr_t evict_addr,
    output logic       fill_ready,
    cache_port_if.src  wr_port,
    cache_port_if.src  rd_port
);

    fill_state_t state;
    bank_t       beat;
    line_addr_t  line;

    assign fill_ready = (state == idle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            beat  <= '0;
        end else begin
            case (state)
                idle: begin
                    beat <= '0;
                    if (fill_start) begin
                        state <= refill;
                    end else if (evict_start) begin
                        state <= evict_issue;
                    end
                end
                refill: begin
                    // beats may have gaps
                    if (fill_valid) begin
                        beat <= beat + 1'b1;
                        if (beat == bank_t'(LINE_BEATS - 1)) begin
                            state <= idle;
                        end
                    end
                end
                evict_issue: begin
                    beat <= beat + 1'b1;
                    if (beat == bank_t'(LINE_BEATS - 1)) begin
                        state <= evict_drain;
                    end
                end
                evict_drain: begin
                    // beat wrapped to 0, now counts the read pipe out
                    beat <= beat + 1'b1;
                    if (beat == bank_t'(READ_LATENCY - 1)) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // latch the line while idle, fill wins a tie
    always_ff @(posedge clk) begin
        if (fill_ready) begin
            line <= fill_start ? fill_addr : evict_addr;
        end
    end

    assign wr_port.en       = (state == refill) && fill_valid;
    assign wr_port.we       = 1'b1;
    assign wr_port.bank_sel = beat;
    assign wr_port.row      = line;
    assign wr_port.data     = fill_data;
    assign wr_port.wm       = '1;

    assign rd_port.en       = (state == evict_issue);
    assign rd_port.we       = 1'b0;
    assign rd_port.bank_sel = beat;
    assign rd_port.row      = line;
    assign rd_port.data     = '0;
    assign rd_port.wm       = '0;

endmodule

`default_nettype wire

// ==== verilog/bank_sram.sv ====
`default_nettype none

module bank_sram import cache_geom_pkg::*; (
    input  logic      clk,
    input  logic      wr_en,
    input  row_addr_t wr_row,
    input  row_data_t wr_data,
    input  row_mask_t wr_mask,
    input  logic      rd_en,
    input  row_addr_t rd_row,
    output row_data_t rd_data
);

    row_data_t mem [ROWS];
    row_data_t rd_q;

    // byte-masked write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < $bits(row_mask_t); i++) begin
                if (wr_mask[i]) begin
                    mem[wr_row][i*BYTE_BITS +: BYTE_BITS] <= wr_data[i*BYTE_BITS +: BYTE_BITS];
                end
            end
        end
    end

    // array read samples before a same-edge write, so old data comes back
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_q <= mem[rd_row];
        end
    end

    // output stage
    always_ff @(posedge clk) begin
        rd_data <= rd_q;
    end

endmodule

`default_nettype wire

// ==== verilog/bank_router.sv ====
`default_nettype none

module bank_router import cache_geom_pkg::*; (
    input  logic       clk,
    cache_port_if.bank st_port,
    cache_port_if.bank fill_wr_port,
    cache_port_if.bank evict_rd_port,
    input  logic       ld_en,
    input  word_addr_t ld_addr,
    output logic       st_busy,
    output logic       ld_busy,
    output logic       ld_accept,
    output row_data_t  bank_rd_data [NUM_BANKS]
);

    bank_t     ld_bank;
    row_addr_t ld_row;

    assign ld_bank = ld_addr[BANK_BITS:1];
    assign ld_row  = ld_addr[ROW_BITS+BANK_BITS:BANK_BITS+1];

    // conflicts are decided only here
    assign st_busy = fill_wr_port.en && fill_wr_port.we &&
                     (fill_wr_port.bank_sel == st_port.bank_sel);
    assign ld_busy = evict_rd_port.en && !evict_rd_port.we &&
                     (evict_rd_port.bank_sel == ld_bank);
    assign ld_accept = ld_en && !ld_busy;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        logic      fill_hit;
        logic      st_hit;
        logic      evict_hit;
        logic      ld_hit;
        logic      wr_en;
        logic      rd_en;
        row_addr_t wr_row;
        row_addr_t rd_row;
        row_data_t wr_data;
        row_mask_t wr_mask;

        assign fill_hit  = fill_wr_port.en && fill_wr_port.we &&
                           (fill_wr_port.bank_sel == bank_t'(b));
        assign st_hit    = st_port.en && st_port.we && (st_port.bank_sel == bank_t'(b));
        assign evict_hit = evict_rd_port.en && !evict_rd_port.we &&
                           (evict_rd_port.bank_sel == bank_t'(b));
        assign ld_hit    = ld_en && (ld_bank == bank_t'(b));

        // fill beats the store, eviction beats the load
        assign wr_en   = fill_hit || st_hit;
        assign wr_row  = fill_hit ? fill_wr_port.row  : st_port.row;
        assign wr_data = fill_hit ? fill_wr_port.data : st_port.data;
        assign wr_mask = fill_hit ? fill_wr_port.wm   : st_port.wm;

        assign rd_en  = evict_hit || ld_hit;
        assign rd_row = evict_hit ? evict_rd_port.row : ld_row;

        bank_sram u_sram (
            .clk     (clk),
            .wr_en   (wr_en),
            .wr_row  (wr_row),
            .wr_data (wr_data),
            .wr_mask (wr_mask),
            .rd_en   (rd_en),
            .rd_row  (rd_row),
            .rd_data (bank_rd_data[b])
        );
    end

endmodule

`default_nettype wire

// ==== verilog/read_align.sv ====
`default_nettype none

module read_align import cache_geom_pkg::*, cache_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ld_accept,
    input  word_addr_t ld_addr,
    cache_port_if.bank evict_rd_port,
    input  row_data_t  bank_rd_data [NUM_BANKS],
    output logic       ld_valid,
    output word_t      ld_data,
    output logic       evict_valid,
    output row_data_t  evict_data
);

    localparam int LAST = READ_LATENCY - 1;

    logic [READ_LATENCY-1:0] ld_vld_q;
    logic [READ_LATENCY-1:0] ev_vld_q;
    logic [READ_LATENCY-1:0] ld_lane_q;
    bank_t                   ld_bank_q [READ_LATENCY];
    bank_t                   ev_bank_q [READ_LATENCY];
    row_data_t               ld_row;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_vld_q <= '0;
            ev_vld_q <= '0;
        end else begin
            ld_vld_q <= {ld_vld_q[LAST-1:0], ld_accept};
            ev_vld_q <= {ev_vld_q[LAST-1:0], evict_rd_port.en && !evict_rd_port.we};
        end
    end

    // select fields ride alongside the bank pipe
    always_ff @(posedge clk) begin
        ld_lane_q    <= {ld_lane_q[LAST-1:0], ld_addr[0]};
        ld_bank_q[0] <= ld_addr[BANK_BITS:1];
        ev_bank_q[0] <= evict_rd_port.bank_sel;
        for (int i = 1; i < READ_LATENCY; i++) begin
            ld_bank_q[i] <= ld_bank_q[i-1];
            ev_bank_q[i] <= ev_bank_q[i-1];
        end
    end

    assign ld_valid    = ld_vld_q[LAST];
    assign evict_valid = ev_vld_q[LAST];

    assign ld_row  = bank_rd_data[ld_bank_q[LAST]];
    assign ld_data = ld_row[ld_lane_q[LAST]*WORD_BITS +: WORD_BITS];

    assign evict_data = bank_rd_data[ev_bank_q[LAST]];

endmodule

`default_nettype wire

// ==== verilog/dcache_array.sv ====
`default_nettype none

module dcache_array (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         st_en,
    input  cache_geom_pkg::word_addr_t   st_addr,
    input  cache_geom_pkg::word_t        st_data,
    input  cache_geom_pkg::word_mask_t   st_mask,
    output logic                         st_busy,
    input  logic                         ld_en,
    input  cache_geom_pkg::word_addr_t   ld_addr,
    output logic                         ld_busy,
    output logic                         ld_valid,
    output cache_geom_pkg::word_t        ld_data,
    input  logic                         fill_start,
    input  cache_geom_pkg::line_addr_t   fill_addr,
    output logic                         fill_ready,
    input  logic                         fill_valid,
    input  cache_geom_pkg::row_data_t    fill_data,
    input  logic                         evict_start,
    input  cache_geom_pkg::line_addr_t   evict_addr,
    output logic                         evict_valid,
    output cache_geom_pkg::row_data_t    evict_data
);

    cache_port_if st_port ();
    cache_port_if fill_wr_port ();
    cache_port_if evict_rd_port ();

    logic                      ld_accept;
    cache_geom_pkg::row_data_t bank_rd_data [cache_geom_pkg::NUM_BANKS];

    store_merge u_store_merge (
        .st_en   (st_en),
        .st_addr (st_addr),
        .st_data (st_data),
        .st_mask (st_mask),
        .port    (st_port)
    );

    fill_engine u_fill_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .fill_start  (fill_start),
        .fill_addr   (fill_addr),
        .fill_valid  (fill_valid),
        .fill_data   (fill_data),
        .evict_start (evict_start),
        .evict_addr  (evict_addr),
        .fill_ready  (fill_ready),
        .wr_port     (fill_wr_port),
        .rd_port     (evict_rd_port)
    );

    bank_router u_bank_router (
        .clk           (clk),
        .st_port       (st_port),
        .fill_wr_port  (fill_wr_port),
        .evict_rd_port (evict_rd_port),
        .ld_en         (ld_en),
        .ld_addr       (ld_addr),
        .st_busy       (st_busy),
        .ld_busy       (ld_busy),
        .ld_accept     (ld_accept),
        .bank_rd_data  (bank_rd_data)
    );

    read_align u_read_align (
        .clk           (clk),
        .rst_n         (rst_n),
        .ld_accept     (ld_accept),
        .ld_addr       (ld_addr),
        .evict_rd_port (evict_rd_port),
        .bank_rd_data  (bank_rd_data),
        .ld_valid      (ld_valid),
        .ld_data       (ld_data),
        .evict_valid   (evict_valid),
        .evict_data    (evict_data)
    );

endmodule

`default_nettype wire

// ==== test/dcache_array_props.sv ====
`default_nettype none

module dcache_array_props (
    input logic clk,
    input logic rst_n,
    input logic ld_en,
    input logic ld_busy,
    input logic ld_valid,
    input logic evict_valid,
    input logic st_busy,
    input logic fill_valid,
    input logic fill_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // accepted load returns two edges later, and nothing else does
    assert property (@(posedge clk) disable iff (!rst_n)
        (ld_en && !ld_busy) |-> ##2 ld_valid)
        else $error("accepted load did not return ld_valid after two cycles");

    assert property (@(posedge clk) disable iff (!rst_n)
        ld_valid |-> $past(ld_en && !ld_busy, 2))
        else $error("ld_valid without an accepted load two cycles before");

    // four rows per eviction
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(evict_valid) |-> evict_valid [*4] ##1 !evict_valid)
        else $error("evict_valid run is not four cycles long");

    assert property (@(posedge clk) disable iff (!rst_n)
        st_busy |-> (fill_valid && !fill_ready))
        else $error("st_busy raised outside a refill beat");

endmodule

bind dcache_array dcache_array_props props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ld_en       (ld_en),
    .ld_busy     (ld_busy),
    .ld_valid    (ld_valid),
    .evict_valid (evict_valid),
    .st_busy     (st_busy),
    .fill_valid  (fill_valid),
    .fill_ready  (fill_ready)
);

`default_nettype wire

// ==== test/dcache_array_tb.sv ====
`default_nettype none

module dcache_array_tb import cache_geom_pkg::*, cache_ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;
    // preload is five cycles per line, the directed tests are short
    localparam int RUN_CYCLES = 8 + ROWS * 5 + 64 * 2 + 200;

    logic       clk;
    logic       rst_n;
    logic       st_en;
    word_addr_t st_addr;
    word_t      st_data;
    word_mask_t st_mask;
    logic       st_busy;
    logic       ld_en;
    word_addr_t ld_addr;
    logic       ld_busy;
    logic       ld_valid;
    word_t      ld_data;
    logic       fill_start;
    line_addr_t fill_addr;
    logic       fill_ready;
    logic       fill_valid;
    row_data_t  fill_data;
    logic       evict_start;
    line_addr_t evict_addr;
    logic       evict_valid;
    row_data_t  evict_data;

    word_t       ref_mem [1024];
    logic [15:0] lfsr_q;
    string       cur_test;
    int          test_errors;
    int          total_errors;
    int          checks;
    int          tests_run;

    dcache_array dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .st_en       (st_en),
        .st_addr     (st_addr),
        .st_data     (st_data),
        .st_mask     (st_mask),
        .st_busy     (st_busy),
        .ld_en       (ld_en),
        .ld_addr     (ld_addr),
        .ld_busy     (ld_busy),
        .ld_valid    (ld_valid),
        .ld_data     (ld_data),
        .fill_start  (fill_start),
        .fill_addr   (fill_addr),
        .fill_ready  (fill_ready),
        .fill_valid  (fill_valid),
        .fill_data   (fill_data),
        .evict_start (evict_start),
        .evict_addr  (evict_addr),
        .evict_valid (evict_valid),
        .evict_data  (evict_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (RUN_CYCLES + 200));
        $display("watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic word_t merge_word(input word_t old, input word_t data,
                                         input word_mask_t mask);
        word_t res;
        res = old;
        for (int b = 0; b < $bits(word_mask_t); b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic word_t pattern_word(input word_addr_t a);
        return {6'h2b, ~a, 6'h14, a};
    endfunction

    function automatic row_data_t ref_row(input line_addr_t line, input bank_t k);
        return {ref_mem[{line, k, 1'b1}], ref_mem[{line, k, 1'b0}]};
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_row(input string what, input row_data_t exp, input row_data_t act);
        checks++;
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("ERROR %s %s: expected %b, actual %b", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d errors", cur_test, test_errors);
        end
    endtask

    task automatic wait_fill_ready();
        int n;
        n = 0;
        while (fill_ready !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (fill_ready !== 1'b1) begin
            $display("%s: fill engine did not return to idle", cur_test);
            test_errors++;
        end
    endtask

    task automatic begin_refill(input line_addr_t line);
        wait_fill_ready();
        fill_start = 1'b1;
        fill_addr  = line;
        @(negedge clk);
        fill_start = 1'b0;
    endtask

    // one beat, recorded in the reference as it is driven
    task automatic drive_beat(input line_addr_t line, input bank_t k, input row_data_t row);
        fill_valid = 1'b1;
        fill_data  = row;
        ref_mem[{line, k, 1'b0}] = row[31:0];
        ref_mem[{line, k, 1'b1}] = row[63:32];
    endtask

    task automatic refill_line(input line_addr_t line, input logic rand_data);
        row_data_t row;
        begin_refill(line);
        for (int k = 0; k < LINE_BEATS; k++) begin
            if (rand_data) begin
                row = {rand_bits(32), rand_bits(32)};
                // gap before odd beats
                if (k % 2 == 1) begin
                    @(negedge clk);
                end
            end else begin
                row = {pattern_word({line, bank_t'(k), 1'b1}),
                       pattern_word({line, bank_t'(k), 1'b0})};
            end
            drive_beat(line, bank_t'(k), row);
            @(negedge clk);
            fill_valid = 1'b0;
        end
    endtask

    task automatic store_word(input word_addr_t addr, input word_t data, input word_mask_t mask);
        st_en   = 1'b1;
        st_addr = addr;
        st_data = data;
        st_mask = mask;
        #2;
        check_bit("st_busy", 1'b0, st_busy);
        ref_mem[addr] = merge_word(ref_mem[addr], data, mask);
        @(negedge clk);
        st_en = 1'b0;
    endtask

    task automatic load_check(input word_addr_t addr);
        ld_en   = 1'b1;
        ld_addr = addr;
        #2;
        check_bit("ld_busy", 1'b0, ld_busy);
        @(negedge clk);
        ld_en = 1'b0;
        check_bit("ld_valid", 1'b0, ld_valid);
        @(negedge clk);
        check_bit("ld_valid", 1'b1, ld_valid);
        check_word("ld_data", ref_mem[addr], ld_data);
    endtask

    task automatic test_reset_state();
        begin_test("reset_state");
        check_bit("st_busy", 1'b0, st_busy);
        check_bit("ld_busy", 1'b0, ld_busy);
        check_bit("ld_valid", 1'b0, ld_valid);
        check_bit("evict_valid", 1'b0, evict_valid);
        check_bit("fill_ready", 1'b1, fill_ready);
        end_test();
    endtask

    task automatic test_preload();
        begin_test("preload");
        for (int l = 0; l < ROWS; l++) begin
            refill_line(line_addr_t'(l), 1'b0);
        end
        end_test();
    endtask

    task automatic test_masked_stores();
        word_addr_t addr;
        begin_test("masked_stores");
        for (int i = 0; i < 8; i++) begin
            addr = word_addr_t'(i * 37 + 5);
            store_word(addr, 32'hc3a5_0000 | i, word_mask_t'(i + 1));
            store_word(addr, 32'h5a00_7e00 + i, ~word_mask_t'(i * 3));
        end
        for (int i = 0; i < 8; i++) begin
            load_check(word_addr_t'(i * 37 + 5));
        end
        end_test();
    endtask

    task automatic test_refill_loads();
        line_addr_t line;
        begin_test("refill_loads");
        line = 7'h2a;
        refill_line(line, 1'b1);
        check_bit("fill_ready", 1'b1, fill_ready);
        for (int w = 0; w < 8; w++) begin
            load_check({line, 3'(w)});
        end
        end_test();
    endtask

    task automatic test_store_collision();
        line_addr_t line;
        word_addr_t target;
        word_t      old_word;
        logic       busy_exp;
        begin_test("store_collision");
        line   = 7'h10;
        target = {7'h55, 2'd1, 1'b1};
        begin_refill(line);
        for (int k = 0; k < LINE_BEATS; k++) begin
            drive_beat(line, bank_t'(k), {rand_bits(32), rand_bits(32)});
            if (k == 1) begin
                st_en   = 1'b1;
                st_addr = target;
                st_data = 32'h5eed_0b1e;
                st_mask = 4'b1101;
            end
            // load in the retry cycle still sees the word from before
            if (k == 2) begin
                ld_en    = 1'b1;
                ld_addr  = target;
                old_word = ref_mem[target];
            end
            #2;
            if (st_en) begin
                busy_exp = (target[2:1] == bank_t'(k));
                check_bit("st_busy", busy_exp, st_busy);
                if (!busy_exp) begin
                    ref_mem[target] = merge_word(ref_mem[target], st_data, st_mask);
                end
            end
            @(negedge clk);
            fill_valid = 1'b0;
            if (k == 2) begin
                st_en = 1'b0;
                ld_en = 1'b0;
            end
        end
        check_bit("ld_valid", 1'b1, ld_valid);
        check_word("ld_data", old_word, ld_data);
        load_check(target);
        for (int w = 0; w < 8; w++) begin
            load_check({line, 3'(w)});
        end
        end_test();
    endtask

    task automatic test_eviction();
        line_addr_t line;
        begin_test("eviction");
        line = 7'h55;
        wait_fill_ready();
        evict_start = 1'b1;
        evict_addr  = line;
        for (int i = 1; i <= 7; i++) begin
            @(negedge clk);
            evict_start = 1'b0;
            ld_en       = 1'b0;
            check_bit("evict_valid", (i >= 3 && i <= 6), evict_valid);
            if (i >= 3 && i <= 6) begin
                check_row("evict_data", ref_row(line, bank_t'(i - 3)), evict_data);
            end
            check_bit("ld_valid", 1'b0, ld_valid);
            // bank 0 is read by the eviction in this cycle
            if (i == 1) begin
                ld_en   = 1'b1;
                ld_addr = {7'h01, 2'd0, 1'b0};
                #2;
                check_bit("ld_busy", 1'b1, ld_busy);
            end
        end
        wait_fill_ready();
        end_test();
    endtask

    task automatic test_random_mix();
        logic       is_store;
        word_addr_t addr;
        word_t      data;
        word_mask_t mask;
        begin_test("random_mix");
        for (int n = 0; n < 64; n++) begin
            is_store = next_bit();
            addr     = word_addr_t'(rand_bits($bits(word_addr_t)));
            if (is_store) begin
                data = rand_bits(32);
                mask = word_mask_t'(rand_bits($bits(word_mask_t)));
                store_word(addr, data, mask);
            end else begin
                load_check(addr);
            end
        end
        end_test();
    endtask

    initial begin
        rst_n        = 1'b0;
        st_en        = 1'b0;
        st_addr      = '0;
        st_data      = '0;
        st_mask      = '0;
        ld_en        = 1'b0;
        ld_addr      = '0;
        fill_start   = 1'b0;
        fill_addr    = '0;
        fill_valid   = 1'b0;
        fill_data    = '0;
        evict_start  = 1'b0;
        evict_addr   = '0;
        lfsr_q       = 16'd94;
        test_errors  = 0;
        total_errors = 0;
        checks       = 0;
        tests_run    = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_reset_state();
        test_preload();
        test_masked_stores();
        test_refill_loads();
        test_store_collision();
        test_eviction();
        test_random_mix();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, total_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache_array.f ====
verilog/cache_geom_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/cache_port_if.sv
verilog/store_merge.sv
verilog/fill_engine.sv
verilog/bank_sram.sv
verilog/bank_router.sv
verilog/read_align.sv
verilog/dcache_array.sv
test/dcache_array_props.sv
test/dcache_array_tb.sv
